// File: run.sh
#!/bin/sh
# build and run the store queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_store_queue -f vlog.f -o sim_store_queue
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/sim_store_queue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
   echo "no result line in sim.log"
   exit 1
fi
exit 0

// File: sq_commit_chk.sv
`timescale 1ns/10ps
`default_nettype none

module sq_commit_chk import sq_pkg::*; (
   input logic       clk,
   input logic       rst,
   input cmt_state_e state,
   input logic       i_str_grnt,
   input logic       i_done,
   input logic       o_str_req,
   input logic       o_str_iss,
   input logic       o_retire
);

   int n_err = 0;   // failed assertion count

   a_req_iss : assert property (@(posedge clk) disable iff (!rst) !(o_str_req && o_str_iss))
      else begin
         n_err++;
         $error("request and issue high in the same cycle");
      end

   // issue only on the grant cycle
   a_iss : assert property (@(posedge clk) disable iff (!rst)
      o_str_iss |-> (state == WAIT_GRANT) && i_str_grnt)
      else begin
         n_err++;
         $error("issue outside WAIT_GRANT or without grant");
      end

   a_retire : assert property (@(posedge clk) disable iff (!rst)
      o_retire |-> (state == ISSUED) && i_done)   // done closes the write
      else begin
         n_err++;
         $error("retire outside ISSUED or without done");
      end

endmodule

bind sq_commit_ctrl sq_commit_chk u_chk (.clk, .rst, .state, .i_str_grnt, .i_done,
   .o_str_req, .o_str_iss, .o_retire);

`default_nettype wire

// File: sq_commit_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module sq_commit_ctrl import sq_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      i_cmmt_str,
   input  logic      i_str_grnt,
   input  logic      i_done,
   sq_entry_if.cmt   ent,
   output logic      o_str_req,
   output logic      o_str_iss,
   output logic      o_retire,
   output sq_ptr_t   o_head,
   output mem_addr_t o_addr,
   output mem_data_t o_data_ca
);

   cmt_state_e state;
   cmt_state_e state_nxt;
   sq_ptr_t    head;
   logic       head_rdy;

   assign head_rdy = ent.ready[head];

   always_comb begin
      state_nxt = state;
      o_str_req = 1'b0;
      o_str_iss = 1'b0;
      o_retire  = 1'b0;
      case (state)
         IDLE:
            if (i_cmmt_str)
               state_nxt = head_rdy ? WAIT_GRANT : WAIT_READY;
         WAIT_READY:
            if (head_rdy)
               state_nxt = WAIT_GRANT;
         WAIT_GRANT:
            if (i_str_grnt) begin
               o_str_iss = 1'b1;
               state_nxt = ISSUED;
            end else begin
               o_str_req = 1'b1;   // keep asking until granted
            end
         ISSUED:
            if (i_done) begin
               o_retire  = 1'b1;
               state_nxt = IDLE;
            end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state <= IDLE;
         head  <= '0;
      end else begin
         state <= state_nxt;
         if (o_retire)
            head <= head + 1'b1;
      end
   end

   assign o_head    = head;
   assign o_addr    = ent.addr[head];
   assign o_data_ca = ent.data[head];

endmodule

`default_nettype wire

// File: sq_entry_array.sv
`timescale 1ns/10ps
`default_nettype none

module sq_entry_array import sq_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  sq_mask_t  i_ins_mask,
   input  rob_tag_t  i_ins_tag [SQ_DEPTH],
   input  sq_mask_t  i_flush_mask,
   input  logic      i_retire,
   input  sq_ptr_t   i_head,
   input  logic      i_mem_wrt,
   input  ls_tag_t   i_indx_ls,
   input  mem_addr_t i_addr_ls,
   input  mem_data_t i_data_str,
   output sq_mask_t  o_busy,
   sq_entry_if.arr   ent
);

   sq_mask_t  busy;
   sq_mask_t  ready;
   sq_mask_t  upd;
   sq_mask_t  ret_mask;
   rob_tag_t  tag  [SQ_DEPTH];
   mem_addr_t addr [SQ_DEPTH];
   mem_data_t data [SQ_DEPTH];

   assign ret_mask = i_retire ? (sq_mask_t'(1) << i_head) : '0;

   // load/store unit reports by the low tag bits
   always_comb begin
      for (int i = 0; i < SQ_DEPTH; i++)
         upd[i] = i_mem_wrt & busy[i] & ~ready[i] & (ls_tag_t'(tag[i]) == i_indx_ls);
   end

   // flush, then retire, then insert
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         busy  <= '0;
         ready <= '0;
      end else begin
         busy  <= (busy | i_ins_mask) & ~i_flush_mask & ~ret_mask;
         ready <= (ready | upd) & ~(i_flush_mask | ret_mask | i_ins_mask);
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < SQ_DEPTH; i++) begin
         if (i_ins_mask[i])
            tag[i] <= i_ins_tag[i];
         if (upd[i]) begin
            addr[i] <= i_addr_ls;
            data[i] <= i_data_str;
         end
      end
   end

   assign o_busy    = busy;
   assign ent.busy  = busy;
   assign ent.ready = ready;
   assign ent.tag   = tag;
   assign ent.addr  = addr;
   assign ent.data  = data;

endmodule

`default_nettype wire

// File: sq_entry_if.sv
`timescale 1ns/10ps
`default_nettype none

interface sq_entry_if import sq_pkg::*; ();

   sq_mask_t  busy;              // allocated, not yet in cache
   sq_mask_t  ready;             // address and data present
   rob_tag_t  tag  [SQ_DEPTH];
   mem_addr_t addr [SQ_DEPTH];
   mem_data_t data [SQ_DEPTH];

   modport arr (output busy, output ready, output tag, output addr, output data);

   modport fwd (input busy, input ready, input tag, input addr, input data);

   // commit only looks at the head entry
   modport cmt (input ready, input addr, input data);

endinterface

`default_nettype wire

// File: sq_fwd_unit.sv
`timescale 1ns/10ps
`default_nettype none

module sq_fwd_unit import sq_pkg::*; (
   input  mem_addr_t i_addr_fwd,
   input  rob_tag_t  i_indx_fwd,
   input  sq_ptr_t   i_head,
   sq_entry_if.fwd   ent,
   output logic      o_fwd,
   output logic      o_fwd_rdy,
   output mem_data_t o_data_fwd
);

   sq_mask_t older;     // store precedes the load
   sq_mask_t match;
   sq_mask_t rdy_vec;
   sq_mask_t rot;       // match reordered to start at head
   sq_ptr_t  ofs;
   sq_ptr_t  sel;

   always_comb begin
      for (int i = 0; i < SQ_DEPTH; i++) begin
         older[i]   = ent.tag[i] < i_indx_fwd;
         match[i]   = ent.busy[i] & older[i] & (ent.addr[i] == i_addr_fwd);
         rdy_vec[i] = ~ent.busy[i] | ent.ready[i] | ~older[i];
      end
   end

   // youngest match is the one farthest from head
   always_comb begin
      sq_ptr_t idx;
      ofs = '0;
      for (int j = 0; j < SQ_DEPTH; j++) begin
         idx    = i_head + sq_ptr_t'(j);
         rot[j] = match[idx];
         if (rot[j])
            ofs = sq_ptr_t'(j);
      end
   end

   assign sel        = i_head + ofs;
   assign o_fwd      = |match;
   assign o_fwd_rdy  = &rdy_vec;
   assign o_data_fwd = o_fwd ? ent.data[sel] : '0;

endmodule

`default_nettype wire

// File: sq_pkg.sv
`default_nettype none

package sq_pkg;

   localparam int SQ_DEPTH    = 16;
   localparam int ALLOC_WIDTH = 4;
   localparam int PTR_W       = $clog2(SQ_DEPTH);
   localparam int TAG_W       = 7;
   localparam int LS_TAG_W    = 6;
   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 16;
   localparam int SLOT_W      = 8;   // valid bit above a 7-bit tag

   // entry index, wraps modulo SQ_DEPTH
   typedef logic [PTR_W-1:0] sq_ptr_t;

   // one bit per entry
   typedef logic [SQ_DEPTH-1:0] sq_mask_t;

   typedef logic [TAG_W-1:0]    rob_tag_t;
   typedef logic [LS_TAG_W-1:0] ls_tag_t;
   typedef logic [ADDR_W-1:0]   mem_addr_t;
   typedef logic [DATA_W-1:0]   mem_data_t;

   // slot 0 sits in the low byte
   typedef logic [ALLOC_WIDTH*SLOT_W-1:0] alloc_bus_t;

   typedef enum logic [1:0] {
      IDLE,
      WAIT_READY,   // head entry still missing address or data
      WAIT_GRANT,
      ISSUED        // waiting for the cache to finish
   } cmt_state_e;

endpackage

`default_nettype wire

// File: sq_ptr_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module sq_ptr_ctrl import sq_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  alloc_bus_t i_alloc,
   input  logic       i_flsh,
   input  sq_ptr_t    i_mis_pred_str_ptr,
   input  sq_mask_t   i_busy,
   output sq_mask_t   o_ins_mask,
   output rob_tag_t   o_ins_tag [SQ_DEPTH],
   output sq_mask_t   o_flush_mask,
   output logic       o_stll
);

   logic [ALLOC_WIDTH-1:0] vld;
   rob_tag_t               slot_tag [ALLOC_WIDTH];
   logic [2:0]             alloc_cnt;
   sq_ptr_t                tail;
   sq_ptr_t                flush_cnt;

   always_comb begin
      for (int k = 0; k < ALLOC_WIDTH; k++) begin
         vld[k]      = i_alloc[SLOT_W*k + TAG_W];
         slot_tag[k] = i_alloc[SLOT_W*k +: TAG_W];
      end
      case (vld)   // only contiguous groups from slot 0 count
         4'b0001: alloc_cnt = 3'd1;
         4'b0011: alloc_cnt = 3'd2;
         4'b0111: alloc_cnt = 3'd3;
         4'b1111: alloc_cnt = 3'd4;
         default: alloc_cnt = 3'd0;
      endcase
   end

   // slot k lands in entry tail+k
   always_comb begin
      sq_ptr_t slot_ptr;
      o_ins_mask = '0;
      o_ins_tag  = '{default: '0};
      for (int k = 0; k < ALLOC_WIDTH; k++) begin
         slot_ptr = tail + sq_ptr_t'(k);
         if ((k < alloc_cnt) && !i_flsh) begin
            o_ins_mask[slot_ptr] = 1'b1;
            o_ins_tag[slot_ptr]  = slot_tag[k];
         end
      end
   end

   // squashed range runs from the mispredict pointer up to tail-1
   assign flush_cnt = tail - i_mis_pred_str_ptr;

   always_comb begin
      sq_ptr_t ofs;
      for (int i = 0; i < SQ_DEPTH; i++) begin
         ofs             = sq_ptr_t'(i) - i_mis_pred_str_ptr;
         o_flush_mask[i] = i_flsh & (ofs < flush_cnt);
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         tail <= '0;
      else if (i_flsh)
         tail <= i_mis_pred_str_ptr;   // rollback, allocation dropped
      else
         tail <= tail + sq_ptr_t'(alloc_cnt);
   end

   assign o_stll = i_busy[tail];   // wrapped onto a live entry

endmodule

`default_nettype wire

// File: store_queue.sv
`timescale 1ns/10ps
`default_nettype none

module store_queue import sq_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  alloc_bus_t i_alloc,
   input  logic       i_flsh,
   input  sq_ptr_t    i_mis_pred_str_ptr,
   input  logic       i_mem_wrt,
   input  ls_tag_t    i_indx_ls,
   input  mem_addr_t  i_addr_ls,
   input  mem_data_t  i_data_str,
   input  logic       i_cmmt_str,
   input  logic       i_str_grnt,
   input  logic       i_done,
   input  mem_addr_t  i_addr_fwd,
   input  rob_tag_t   i_indx_fwd,
   output logic       o_stll,
   output logic       o_str_req,
   output logic       o_str_iss,
   output mem_addr_t  o_addr,
   output mem_data_t  o_data_ca,
   output logic       o_fwd,
   output logic       o_fwd_rdy,
   output mem_data_t  o_data_fwd
);

   sq_mask_t ins_mask;
   rob_tag_t ins_tag [SQ_DEPTH];
   sq_mask_t flush_mask;
   sq_mask_t busy;
   logic     retire;
   sq_ptr_t  head;

   sq_entry_if u_ent_if ();

   sq_ptr_ctrl u_ptr (.clk, .rst, .i_alloc, .i_flsh, .i_mis_pred_str_ptr,
      .i_busy(busy), .o_ins_mask(ins_mask), .o_ins_tag(ins_tag),
      .o_flush_mask(flush_mask), .o_stll);

   sq_entry_array u_arr (.clk, .rst, .i_ins_mask(ins_mask), .i_ins_tag(ins_tag),
      .i_flush_mask(flush_mask), .i_retire(retire), .i_head(head), .i_mem_wrt,
      .i_indx_ls, .i_addr_ls, .i_data_str, .o_busy(busy), .ent(u_ent_if.arr));

   sq_commit_ctrl u_cmt (.clk, .rst, .i_cmmt_str, .i_str_grnt, .i_done,
      .ent(u_ent_if.cmt), .o_str_req, .o_str_iss, .o_retire(retire),
      .o_head(head), .o_addr, .o_data_ca);

   sq_fwd_unit u_fwd (.i_addr_fwd, .i_indx_fwd, .i_head(head), .ent(u_ent_if.fwd),
      .o_fwd, .o_fwd_rdy, .o_data_fwd);

endmodule

`default_nettype wire

// File: tb_store_queue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_store_queue import sq_pkg::*; ();

   localparam int MAX_CYCLES = 600;   // about four times the whole run

   logic       clk = 1'b0;
   logic       rst = 1'b0;
   alloc_bus_t i_alloc = '0;
   logic       i_flsh = 1'b0;
   sq_ptr_t    i_mis_pred_str_ptr = '0;
   logic       i_mem_wrt = 1'b0;
   ls_tag_t    i_indx_ls = '0;
   mem_addr_t  i_addr_ls = '0;
   mem_data_t  i_data_str = '0;
   logic       i_cmmt_str = 1'b0;
   logic       i_str_grnt = 1'b0;
   logic       i_done = 1'b0;
   mem_addr_t  i_addr_fwd = '0;
   rob_tag_t   i_indx_fwd = '0;
   logic       o_stll, o_str_req, o_str_iss, o_fwd, o_fwd_rdy;
   mem_addr_t  o_addr;
   mem_data_t  o_data_ca, o_data_fwd;

   int    cycles = 0;
   int    test_errs = 0;
   int    n_pass = 0;
   int    n_fail = 0;
   string test_name;

   store_queue u_dut (.*);

   initial begin
      forever #2 clk = ~clk;
   end

   task automatic check(input logic [15:0] exp, input logic [15:0] act, input string what);
      assert (act === exp) else begin
         $display("** Error %s: %s expected %0h actual %0h", test_name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic reset_dut();
      rst = 1'b0;
      repeat (5) @(negedge clk);
      rst = 1'b1;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
      reset_dut();
   endtask

   task automatic finish_test();
      if (test_errs == 0)
         n_pass++;
      else
         n_fail++;
      $display("test %s %s", test_name, (test_errs == 0) ? "passed" : "failed");
   endtask

   // slots 0..n-1 valid for one cycle with tags base+k
   task automatic alloc(input int n, input rob_tag_t base);
      @(negedge clk);
      for (int k = 0; k < n; k++)
         i_alloc[SLOT_W*k +: SLOT_W] = {1'b1, base + rob_tag_t'(k)};
      @(negedge clk);
      i_alloc = '0;
   endtask

   task automatic update(input rob_tag_t tag, input mem_addr_t a, input mem_data_t d);
      @(negedge clk);
      i_mem_wrt  = 1'b1;
      i_indx_ls  = ls_tag_t'(tag);
      i_addr_ls  = a;
      i_data_str = d;
      @(negedge clk);
      i_mem_wrt = 1'b0;
   endtask

   task automatic flush(input sq_ptr_t p);
      @(negedge clk);
      i_flsh             = 1'b1;
      i_mis_pred_str_ptr = p;
      @(negedge clk);
      i_flsh = 1'b0;
   endtask

   task automatic load(input mem_addr_t a, input rob_tag_t t);
      @(negedge clk);
      i_addr_fwd = a;
      i_indx_fwd = t;
      #1;   // forwarding is combinational
   endtask

   task automatic commit_pulse();
      @(negedge clk);
      i_cmmt_str = 1'b1;
      @(negedge clk);
      i_cmmt_str = 1'b0;
   endtask

   // cache side of one write from request to done
   task automatic cache_write(input mem_addr_t a, input mem_data_t d);
      while (!o_str_req)
         @(negedge clk);
      check(a, o_addr, "o_addr");
      check(d, o_data_ca, "o_data_ca");
      @(negedge clk);
      check(1, o_str_req, "o_str_req before grant");
      i_str_grnt = 1'b1;
      #1;
      check(1, o_str_iss, "o_str_iss");
      check(0, o_str_req, "o_str_req at grant");
      @(negedge clk);
      i_str_grnt = 1'b0;
      i_done     = 1'b1;
      check(0, o_str_iss, "o_str_iss after grant");
      @(negedge clk);
      i_done = 1'b0;
   endtask

   task automatic reset_values();
      start_test("reset");
      check(0, o_stll, "o_stll");
      check(0, o_str_req, "o_str_req");
      check(0, o_str_iss, "o_str_iss");
      check(0, o_fwd, "o_fwd");
      check(1, o_fwd_rdy, "o_fwd_rdy");
      finish_test();
   endtask

   task automatic alloc_and_stall();
      int used;
      start_test("alloc_stall");
      used = 0;
      for (int g = 0; g < 4; g++) begin
         alloc(4, rob_tag_t'(4*g));
         used += 4;
         check(used == SQ_DEPTH, o_stll, "o_stll full");
      end
      reset_dut();
      for (int g = 0; g < 3; g++)
         alloc(4, rob_tag_t'(4*g));
      @(negedge clk);
      i_alloc = {8'h00, 8'h8e, 8'h00, 8'h8c};   // pattern 0101 is not contiguous
      @(negedge clk);
      i_alloc = '0;
      check(0, o_stll, "o_stll after 0101");
      alloc(3, 7'd12);   // 15 entries used with the tail on entry 15
      check(0, o_stll, "o_stll at 15");
      alloc(1, 7'd15);
      check(1, o_stll, "o_stll at 16");
      finish_test();
   endtask

   task automatic update_and_commit();
      mem_addr_t a0, a1;
      mem_data_t d0, d1;
      start_test("commit");
      a0 = mem_addr_t'($urandom);
      a1 = mem_addr_t'($urandom);
      d0 = mem_data_t'($urandom);
      d1 = mem_data_t'($urandom);
      alloc(2, 7'd10);
      update(7'd10, a0, d0);
      update(7'd11, a1, d1);
      commit_pulse();
      cache_write(a0, d0);
      check(a1, o_addr, "o_addr next entry");
      check(d1, o_data_ca, "o_data_ca next entry");
      reset_dut();
      alloc(1, 7'd20);
      commit_pulse();
      repeat (3) @(negedge clk);
      check(0, o_str_req, "o_str_req head not ready");
      update(7'd20, a1, d0);
      cache_write(a1, d0);
      finish_test();
   endtask

   task automatic forward_and_ready();
      mem_addr_t a;
      mem_data_t d0, d1;
      start_test("forward");
      a  = mem_addr_t'($urandom);
      d0 = mem_data_t'($urandom);
      d1 = mem_data_t'($urandom);
      alloc(3, 7'd10);   // store tagged 12 never gets an update
      update(7'd10, a, d0);
      update(7'd11, a, d1);
      load(a, 7'd12);
      check(1, o_fwd, "o_fwd");
      check(d1, o_data_fwd, "later store");
      check(1, o_fwd_rdy, "o_fwd_rdy");
      load(a, 7'd11);
      check(d0, o_data_fwd, "earlier store");
      load(a ^ 16'h8000, 7'd12);
      check(0, o_fwd, "o_fwd other addr");
      check(0, o_data_fwd, "data other addr");
      load(a, 7'd13);
      check(0, o_fwd_rdy, "o_fwd_rdy pending store");
      finish_test();
   endtask

   task automatic flush_and_refill();
      mem_addr_t a;
      mem_data_t d0, d1;
      start_test("flush");
      a  = mem_addr_t'($urandom);
      d0 = mem_data_t'($urandom);
      d1 = mem_data_t'($urandom);
      alloc(2, 7'd10);
      update(7'd10, a, d0);
      update(7'd11, a, d1);
      load(a, 7'd12);
      check(d1, o_data_fwd, "before flush");
      flush(4'd1);
      check(d0, o_data_fwd, "after flush");
      for (int g = 0; g < 3; g++)
         alloc(4, rob_tag_t'(20 + 4*g));
      alloc(2, 7'd40);   // tail restarted at entry 1 so 15 are used
      check(0, o_stll, "o_stll at 15");
      alloc(1, 7'd42);
      check(1, o_stll, "o_stll full");
      flush(4'd1);
      check(0, o_stll, "o_stll after flush");
      finish_test();
   endtask

   initial begin
      void'($urandom(12062));
      reset_values();
      alloc_and_stall();
      update_and_commit();
      forward_and_ready();
      flush_and_refill();
      $display("tests passed %0d failed %0d assertion failures %0d", n_pass, n_fail,
         u_dut.u_cmt.u_chk.n_err);
      if ((n_fail == 0) && (u_dut.u_cmt.u_chk.n_err == 0))
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
sq_pkg.sv
sq_entry_if.sv
sq_ptr_ctrl.sv
sq_entry_array.sv
sq_commit_ctrl.sv
sq_fwd_unit.sv
store_queue.sv
sq_commit_chk.sv
tb_store_queue.sv
